//--- src/ppu_pkg.sv
// ==========================================================================
// Processing unit shared definitions
// Task kind encoding and width helpers used across the unit
// ==========================================================================

package ppu_pkg;

    // Prefix source of a task
    // TASK_NULL means the prefix id was all ones and the row is seeded
    typedef enum logic {
        TASK_PREFIX = 1'b0,
        TASK_NULL   = 1'b1
    } task_kind_e;

    // Index width for a table of n entries, never below one bit
    function automatic int id_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Bits in one packed partial-sum row
    function automatic int row_width(input int pe_count, input int acc_width);
        return pe_count * acc_width;
    endfunction

endpackage

//--- src/task_decoder.sv
// ==========================================================================
// Task decoder
// Captures a task, detects the null prefix and walks the spike pattern
// with a bit-scan-forward decoder, one set spike per cycle
// ==========================================================================

`timescale 1ns/1ns

module task_decoder #(
    parameter int ROWS   = 16,
    parameter int SPIKES = 8,
    localparam int ID_W  = ppu_pkg::id_width(ROWS),
    localparam int SP_W  = ppu_pkg::id_width(SPIKES)
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Task side
    input  logic                 task_valid,
    input  logic [ID_W-1:0]      task_row_id,
    input  logic [ID_W-1:0]      task_prefix_id,
    input  logic [SPIKES-1:0]    task_pattern,
    output logic                 task_ready,
    output logic                 proc_busy,
    output logic                 proc_done,

    // Controls toward the element array
    output ppu_pkg::task_kind_e  task_kind,
    output logic [SPIKES-1:0]    seed_pattern,
    output logic                 load_en,
    output logic                 acc_en,
    output logic [SP_W-1:0]      spike_idx,

    // Controls toward the row buffer
    output logic [ID_W-1:0]      pfx_rd_row,
    output logic [ID_W-1:0]      wr_row,
    output logic                 wr_en
);

    import ppu_pkg::*;

    // All-ones id marks a task without a prefix
    localparam logic [ID_W-1:0] NULL_ID = ID_W'(ROWS - 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_LOAD = 2'd1;
    localparam logic [1:0] ST_SCAN = 2'd2;
    localparam logic [1:0] ST_WB   = 2'd3;

    logic [1:0]        state;
    logic [1:0]        state_nxt;
    logic              accept;

    // Captured task fields
    logic [ID_W-1:0]   row_q;
    logic [ID_W-1:0]   pfx_q;
    logic [SPIKES-1:0] pat_q;
    task_kind_e        kind_q;

    // Working copy of the pattern, one bit removed per scan cycle
    logic [SPIKES-1:0] work_q;
    logic [SPIKES-1:0] work_clr;

    logic [SP_W-1:0]   bsf_idx;
    logic              bsf_hit;

    assign accept = task_valid && (state == ST_IDLE);

    // ======================================================================
    // Task capture
    // ======================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            row_q  <= task_row_id;
            pfx_q  <= task_prefix_id;
            pat_q  <= task_pattern;
            kind_q <= (task_prefix_id == NULL_ID) ? TASK_NULL : TASK_PREFIX;
        end
    end

    // Load on accept, then clear the scanned bit each scan cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            work_q <= task_pattern;
        end else if (state == ST_SCAN) begin
            work_q <= work_clr;
        end
    end

    // ======================================================================
    // Bit scan forward
    // ======================================================================

    // Lowest set bit wins
    always_comb begin
        bsf_idx = '0;
        bsf_hit = 1'b0;
        for (int b = 0; b < SPIKES; b++) begin
            if (work_q[b] && !bsf_hit) begin
                bsf_idx = SP_W'(b);
                bsf_hit = 1'b1;
            end
        end
    end

    // Pattern as it will look once the current spike is consumed
    always_comb begin
        work_clr = work_q;
        work_clr[bsf_idx] = 1'b0;
    end

    // ======================================================================
    // Sequencing FSM
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (task_valid) begin
                    state_nxt = ST_LOAD;
                end
            end
            ST_LOAD: begin
                // Null task or empty suffix has nothing to accumulate
                if (kind_q == TASK_NULL || !bsf_hit) begin
                    state_nxt = ST_WB;
                end else begin
                    state_nxt = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (work_clr == '0) begin
                    state_nxt = ST_WB;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Status and control strobes come straight from the state
    assign task_ready   = (state == ST_IDLE);
    assign proc_busy    = (state != ST_IDLE);
    assign proc_done    = (state == ST_WB);
    assign load_en      = (state == ST_LOAD);
    assign acc_en       = (state == ST_SCAN);
    assign wr_en        = (state == ST_WB);
    assign spike_idx    = bsf_idx;

    assign task_kind    = kind_q;
    assign seed_pattern = pat_q;
    assign pfx_rd_row   = pfx_q;
    assign wr_row       = row_q;

    // Each scan cycle consumes exactly one spike of the working pattern
    a_scan_one_bit: assert property (@(posedge clk) disable iff (!rst_n)
        acc_en |=> ($countones(work_q) + 1 == $countones($past(work_q))))
        else $error("scan cycle did not clear exactly one spike");

    a_wr_not_acc: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && acc_en))
        else $error("row writeback overlaps accumulation");

endmodule

//--- src/pe_array.sv
// ==========================================================================
// Processing element array
// Weight buffer with direct write port and one accumulator per element,
// seeded from the prefix row or from the spike pattern
// ==========================================================================

`timescale 1ns/1ns

module pe_array #(
    parameter int SPIKES       = 8,
    parameter int PE_COUNT     = 16,
    parameter int WEIGHT_WIDTH = 8,
    parameter int ACC_WIDTH    = 16,
    localparam int SP_W        = ppu_pkg::id_width(SPIKES),
    localparam int PE_W        = ppu_pkg::id_width(PE_COUNT),
    localparam int ROW_W       = ppu_pkg::row_width(PE_COUNT, ACC_WIDTH)
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Weight write port
    input  logic                    wt_wr_en,
    input  logic [PE_W-1:0]         wt_pe,
    input  logic [SP_W-1:0]         wt_spike,
    input  logic [WEIGHT_WIDTH-1:0] wt_data,

    // Seeding
    input  logic                    load_en,
    input  ppu_pkg::task_kind_e     task_kind,
    input  logic [SPIKES-1:0]       seed_pattern,
    input  logic [ROW_W-1:0]        pfx_rd_data,

    // Accumulation
    input  logic                    acc_en,
    input  logic [SP_W-1:0]         spike_idx,

    output logic [ROW_W-1:0]        row_sums
);

    import ppu_pkg::*;

    // Consecutive elements sharing one pattern bit in null seeding
    localparam int GROUP = PE_COUNT / SPIKES;

    // Weight buffer indexed [element][spike]
    logic [WEIGHT_WIDTH-1:0] wbuf [PE_COUNT][SPIKES];

    always_ff @(posedge clk) begin
        if (wt_wr_en) begin
            wbuf[wt_pe][wt_spike] <= wt_data;
        end
    end

    // ======================================================================
    // Element lanes
    // ======================================================================

    for (genvar i = 0; i < PE_COUNT; i++) begin : g_pe
        logic [WEIGHT_WIDTH-1:0] w_sel;
        logic [ACC_WIDTH-1:0]    w_ext;
        logic [ACC_WIDTH-1:0]    acc_q;

        // Weight of this element for the spike under scan
        assign w_sel = wbuf[i][spike_idx];
        assign w_ext = {{(ACC_WIDTH - WEIGHT_WIDTH){w_sel[WEIGHT_WIDTH-1]}}, w_sel};

        always_ff @(posedge clk) begin
            if (load_en) begin
                if (task_kind == TASK_NULL) begin
                    // Seed with the mapped pattern bit as 0 or 1
                    acc_q <= ACC_WIDTH'(seed_pattern[i / GROUP]);
                end else begin
                    acc_q <= pfx_rd_data[i*ACC_WIDTH +: ACC_WIDTH];
                end
            end else if (acc_en) begin
                // Wraps modulo 2**ACC_WIDTH
                acc_q <= acc_q + w_ext;
            end
        end

        // Element 0 lands in the low slice
        assign row_sums[i*ACC_WIDTH +: ACC_WIDTH] = acc_q;
    end

    // Weights only change between tasks
    a_wt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !(wt_wr_en && (load_en || acc_en)))
        else $error("weight write during a running task");

endmodule

//--- src/row_result_buffer.sv
// ==========================================================================
// Row result buffer
// Stores packed partial-sum rows with a prefix read port, a host read
// port and one synchronous write port
// ==========================================================================

`timescale 1ns/1ns

module row_result_buffer #(
    parameter int ROWS      = 16,
    parameter int PE_COUNT  = 16,
    parameter int ACC_WIDTH = 16,
    localparam int ID_W     = ppu_pkg::id_width(ROWS),
    localparam int ROW_W    = ppu_pkg::row_width(PE_COUNT, ACC_WIDTH)
) (
    input  logic             clk,
    input  logic             rst_n,

    // Prefix read toward the element array
    input  logic [ID_W-1:0]  pfx_rd_row,
    output logic [ROW_W-1:0] pfx_rd_data,

    // Host read
    input  logic [ID_W-1:0]  host_rd_row,
    output logic [ROW_W-1:0] host_rd_data,

    // Writeback of a finished row
    input  logic             wr_en,
    input  logic [ID_W-1:0]  wr_row,
    input  logic [ROW_W-1:0] row_sums
);

    localparam logic [ID_W-1:0] NULL_ID = ID_W'(ROWS - 1);

    // Row storage, contents undefined until written
    logic [ROW_W-1:0] rows [ROWS];

    // ======================================================================
    // Write port
    // ======================================================================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            rows[wr_row] <= row_sums;
        end
    end

    // ======================================================================
    // Read ports
    // ======================================================================

    // Zero latency, a write shows up from the next cycle
    assign pfx_rd_data  = rows[pfx_rd_row];
    assign host_rd_data = rows[host_rd_row];

    // The null id is reserved and never holds a result
    a_no_null_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_row != NULL_ID))
        else $error("writeback targets the null row id");

endmodule

//--- src/ppu_processor.sv
// ==========================================================================
// Product-sparsity processing unit
// Decoder, element array and row buffer for one accelerator PE row
// ==========================================================================

`timescale 1ns/1ns

module ppu_processor #(
    parameter int ROWS         = 16,
    parameter int SPIKES       = 8,
    parameter int PE_COUNT     = 16,
    parameter int WEIGHT_WIDTH = 8,
    parameter int ACC_WIDTH    = 16,
    localparam int ID_W        = ppu_pkg::id_width(ROWS),
    localparam int SP_W        = ppu_pkg::id_width(SPIKES),
    localparam int PE_W        = ppu_pkg::id_width(PE_COUNT),
    localparam int ROW_W       = ppu_pkg::row_width(PE_COUNT, ACC_WIDTH)
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Task input
    input  logic                    task_valid,
    output logic                    task_ready,
    input  logic [ID_W-1:0]         task_row_id,
    input  logic [ID_W-1:0]         task_prefix_id,
    input  logic [SPIKES-1:0]       task_pattern,

    // Weight write, only while idle
    input  logic                    wt_wr_en,
    input  logic [PE_W-1:0]         wt_pe,
    input  logic [SP_W-1:0]         wt_spike,
    input  logic [WEIGHT_WIDTH-1:0] wt_data,

    // Host read of stored rows
    input  logic [ID_W-1:0]         host_rd_row,
    output logic [ROW_W-1:0]        host_rd_data,

    // Status
    output logic                    proc_busy,
    output logic                    proc_done
);

    import ppu_pkg::*;

    task_kind_e        task_kind;
    logic [SPIKES-1:0] seed_pattern;
    logic              load_en;
    logic              acc_en;
    logic [SP_W-1:0]   spike_idx;
    logic [ID_W-1:0]   pfx_rd_row;
    logic [ID_W-1:0]   wr_row;
    logic              wr_en;
    logic [ROW_W-1:0]  pfx_rd_data;
    logic [ROW_W-1:0]  row_sums;

    task_decoder #(
        .ROWS   (ROWS),
        .SPIKES (SPIKES)
    ) u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .task_valid     (task_valid),
        .task_row_id    (task_row_id),
        .task_prefix_id (task_prefix_id),
        .task_pattern   (task_pattern),
        .task_ready     (task_ready),
        .proc_busy      (proc_busy),
        .proc_done      (proc_done),
        .task_kind      (task_kind),
        .seed_pattern   (seed_pattern),
        .load_en        (load_en),
        .acc_en         (acc_en),
        .spike_idx      (spike_idx),
        .pfx_rd_row     (pfx_rd_row),
        .wr_row         (wr_row),
        .wr_en          (wr_en)
    );

    pe_array #(
        .SPIKES       (SPIKES),
        .PE_COUNT     (PE_COUNT),
        .WEIGHT_WIDTH (WEIGHT_WIDTH),
        .ACC_WIDTH    (ACC_WIDTH)
    ) u_pe_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .wt_wr_en     (wt_wr_en),
        .wt_pe        (wt_pe),
        .wt_spike     (wt_spike),
        .wt_data      (wt_data),
        .load_en      (load_en),
        .task_kind    (task_kind),
        .seed_pattern (seed_pattern),
        .pfx_rd_data  (pfx_rd_data),
        .acc_en       (acc_en),
        .spike_idx    (spike_idx),
        .row_sums     (row_sums)
    );

    row_result_buffer #(
        .ROWS      (ROWS),
        .PE_COUNT  (PE_COUNT),
        .ACC_WIDTH (ACC_WIDTH)
    ) u_row_buf (
        .clk          (clk),
        .rst_n        (rst_n),
        .pfx_rd_row   (pfx_rd_row),
        .pfx_rd_data  (pfx_rd_data),
        .host_rd_row  (host_rd_row),
        .host_rd_data (host_rd_data),
        .wr_en        (wr_en),
        .wr_row       (wr_row),
        .row_sums     (row_sums)
    );

endmodule

//--- dv/tb_ppu.sv
// ==========================================================================
// Processing unit testbench
// Reference model of rows and weights, LFSR stimulus, and assertions that
// compare status, done timing and stored rows against the model
// ==========================================================================

`timescale 1ns/1ns

module tb_ppu;

    localparam int ROWS = 16;
    localparam int SPIKES = 8;
    localparam int PE_COUNT = 16;
    localparam int WEIGHT_WIDTH = 8;
    localparam int ACC_WIDTH = 16;
    localparam int ID_W = $clog2(ROWS);
    localparam int ROW_W = PE_COUNT * ACC_WIDTH;
    localparam int GROUP = PE_COUNT / SPIKES;
    localparam int NULL_ID = ROWS - 1;
    localparam int N_TASKS = 8 + 24;
    // Reset, weight load, worst case per task, final row sweep, margin
    localparam int MAX_CYCLES = 3 + PE_COUNT * SPIKES + N_TASKS * (SPIKES + 3) + ROWS + 16;

    logic clk = 1'b0;
    logic rst_n;
    logic task_valid;
    logic task_ready;
    logic [ID_W-1:0] task_row_id;
    logic [ID_W-1:0] task_prefix_id;
    logic [SPIKES-1:0] task_pattern;
    logic wt_wr_en;
    logic [$clog2(PE_COUNT)-1:0] wt_pe;
    logic [$clog2(SPIKES)-1:0] wt_spike;
    logic [WEIGHT_WIDTH-1:0] wt_data;
    logic [ID_W-1:0] host_rd_row;
    logic [ROW_W-1:0] host_rd_data;
    logic proc_busy;
    logic proc_done;

    // Model state
    logic [WEIGHT_WIDTH-1:0] model_w [PE_COUNT][SPIKES];
    logic [ROW_W-1:0] model_rows [ROWS];
    logic model_valid [ROWS];
    logic [ROW_W-1:0] exp_row;
    logic [ID_W-1:0] exp_wr_row;
    int exp_n;
    int since;
    logic active;
    logic done_due;
    logic [ROW_W-1:0] model_rd;
    logic model_rd_valid;
    logic [31:0] lfsr_q = 32'h0069153e;
    int cycle_count = 0;

    ppu_processor #(
        .ROWS         (ROWS),
        .SPIKES       (SPIKES),
        .PE_COUNT     (PE_COUNT),
        .WEIGHT_WIDTH (WEIGHT_WIDTH),
        .ACC_WIDTH    (ACC_WIDTH)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .task_valid     (task_valid),
        .task_ready     (task_ready),
        .task_row_id    (task_row_id),
        .task_prefix_id (task_prefix_id),
        .task_pattern   (task_pattern),
        .wt_wr_en       (wt_wr_en),
        .wt_pe          (wt_pe),
        .wt_spike       (wt_spike),
        .wt_data        (wt_data),
        .host_rd_row    (host_rd_row),
        .host_rd_data   (host_rd_data),
        .proc_busy      (proc_busy),
        .proc_done      (proc_done)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[b] = lfsr_q[0];
        end
        return v;
    endfunction

    // Expected row: seed from pattern or prefix, then add each selected weight
    function automatic logic [ROW_W-1:0] predict_row(input logic [ID_W-1:0] pfx,
                                                     input logic [SPIKES-1:0] pat);
        logic [ROW_W-1:0] row;
        logic [ACC_WIDTH-1:0] acc;
        for (int i = 0; i < PE_COUNT; i++) begin
            if (pfx == ID_W'(NULL_ID)) begin
                acc = pat[i / GROUP] ? ACC_WIDTH'(1) : '0;
            end else begin
                acc = model_rows[pfx][i*ACC_WIDTH +: ACC_WIDTH];
                for (int s = 0; s < SPIKES; s++) begin
                    if (pat[s]) begin
                        acc = acc + ACC_WIDTH'($signed(model_w[i][s]));
                    end
                end
            end
            row[i*ACC_WIDTH +: ACC_WIDTH] = acc;
        end
        return row;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    always @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            since <= 0;
            for (int r = 0; r < ROWS; r++) begin
                model_valid[r] <= 1'b0;
            end
        end else begin
            if (wt_wr_en) begin
                model_w[wt_pe][wt_spike] <= wt_data;
            end
            // A task is taken only while the unit is idle
            if (task_valid && !active) begin
                active <= 1'b1;
                since <= 1;
                exp_n <= (task_prefix_id == ID_W'(NULL_ID)) ? 0 : $countones(task_pattern);
                exp_row <= predict_row(task_prefix_id, task_pattern);
                exp_wr_row <= task_row_id;
            end else if (active) begin
                // Row lands in the buffer at the edge ending the done cycle
                if (since == exp_n + 2) begin
                    active <= 1'b0;
                    model_rows[exp_wr_row] <= exp_row;
                    model_valid[exp_wr_row] <= 1'b1;
                end else begin
                    since <= since + 1;
                end
            end
        end
    end

    assign done_due = active && (since == exp_n + 2);
    assign model_rd = model_rows[host_rd_row];
    assign model_rd_valid = model_valid[host_rd_row];

    // ======================================================================
    // Checks
    // ======================================================================

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (task_ready && !proc_busy && !proc_done))
        else stop_on_error($sformatf("Fail at %0t: ready/busy/done after reset %b%b%b, expected 100",
            $time, $sampled(task_ready), $sampled(proc_busy), $sampled(proc_done)));

    a_ready: assert property (@(posedge clk) disable iff (!rst_n) task_ready == !active)
        else stop_on_error($sformatf("Fail at %0t: task_ready is %b, expected %b",
            $time, $sampled(task_ready), $sampled(!active)));

    a_busy: assert property (@(posedge clk) disable iff (!rst_n) proc_busy == active)
        else stop_on_error($sformatf("Fail at %0t: proc_busy is %b, expected %b",
            $time, $sampled(proc_busy), $sampled(active)));

    // Done exactly 2+n cycles after the accepting edge
    a_done: assert property (@(posedge clk) disable iff (!rst_n) proc_done == done_due)
        else stop_on_error($sformatf("Fail at %0t: proc_done is %b, expected %b",
            $time, $sampled(proc_done), $sampled(done_due)));

    a_row: assert property (@(posedge clk) disable iff (!rst_n)
        model_rd_valid |-> (host_rd_data == model_rd))
        else stop_on_error($sformatf("Fail at %0t: host_rd_data row %0d is %h, expected %h",
            $time, $sampled(host_rd_row), $sampled(host_rd_data), $sampled(model_rd)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_on_error("Timeout: the task sequence did not complete in time");
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Starts at a falling edge while idle; hold keeps valid up through done
    // Host port follows the written row from its done cycle to the next done
    task automatic run_task(input int row, input int pfx, input int pat, input bit hold);
        task_valid = 1'b1;
        task_row_id = ID_W'(row);
        task_prefix_id = ID_W'(pfx);
        task_pattern = SPIKES'(pat);
        @(negedge clk);
        if (!hold) begin
            task_valid = 1'b0;
        end
        while (!proc_done) begin
            @(negedge clk);
        end
        task_valid = 1'b0;
        host_rd_row = ID_W'(row);
        @(negedge clk);
    endtask

    initial begin
        int row;
        int pfx;
        rst_n = 1'b0;
        task_valid = 1'b0;
        task_row_id = '0;
        task_prefix_id = '0;
        task_pattern = '0;
        wt_wr_en = 1'b0;
        wt_pe = '0;
        wt_spike = '0;
        wt_data = '0;
        host_rd_row = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Fill the weight buffer, signed values from the LFSR
        for (int p = 0; p < PE_COUNT; p++) begin
            for (int s = 0; s < SPIKES; s++) begin
                wt_wr_en = 1'b1;
                wt_pe = p[$clog2(PE_COUNT)-1:0];
                wt_spike = s[$clog2(SPIKES)-1:0];
                wt_data = WEIGHT_WIDTH'(rand_bits(WEIGHT_WIDTH));
                @(negedge clk);
            end
        end
        wt_wr_en = 1'b0;
        @(negedge clk);

        // Null seeds, then prefix chains, an empty suffix and held valid
        run_task(0, NULL_ID, 'hA6, 1'b0);
        run_task(1, NULL_ID, 'hFF, 1'b0);
        run_task(2, NULL_ID, 'h00, 1'b1);
        run_task(3, 0, 'h01, 1'b0);
        run_task(4, 3, 'hFF, 1'b0);
        run_task(5, 4, 'h81, 1'b1);
        run_task(6, 5, 'h00, 1'b0);
        run_task(6, 6, 'h5A, 1'b1);

        // Random tasks, prefix falls back to null if that row is unwritten
        for (int t = 0; t < N_TASKS - 8; t++) begin
            row = int'(rand_bits(ID_W)) % (ROWS - 1);
            pfx = int'(rand_bits(ID_W));
            if (pfx == NULL_ID || !model_valid[pfx]) begin
                pfx = NULL_ID;
            end
            run_task(row, pfx, int'(rand_bits(SPIKES)), rand_bits(1) != 0);
        end

        // Sweep the host port over every row
        for (int r = 0; r < ROWS - 1; r++) begin
            host_rd_row = ID_W'(r);
            @(negedge clk);
        end
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- files.f
src/ppu_pkg.sv
src/task_decoder.sv
src/pe_array.sv
src/row_result_buffer.sv
src/ppu_processor.sv
dv/tb_ppu.sv

//--- Makefile
TOP := tb_ppu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
